/* rtl/frontend_pkg.sv */
package frontend_pkg;

    localparam int IF_WIDTH = 4;                 // Instructions per fetch block.
    localparam int IF_IDX_W = $clog2(IF_WIDTH);
    localparam int BLK_BYTES = IF_WIDTH * 4;     // 16 bytes per block.
    localparam int BLK_OFF_W = $clog2(BLK_BYTES);

    localparam logic [31:0] RESET_PC = 32'h1eceb000;

    localparam int BHT_ENTRIES = 64;             // Counters per lane.
    localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);
    localparam int BTB_ENTRIES = 16;             // Target entries per lane.
    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W = 32 - BLK_OFF_W - BTB_IDX_W;

    typedef logic [IF_WIDTH-1:0][31:0] inst_block_t;

    // Block sent to the decode FIFO.
    typedef struct packed {
        logic [31:0]               pc;              // Aligned block address.
        inst_block_t               insts;
        logic [IF_WIDTH-1:0]       valid;
        logic [IF_WIDTH-1:0]       predict_taken;
        logic [IF_WIDTH-1:0][31:0] predict_target;
    } fetch_packet_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } lane_pred_t;

    // Resolved branch from commit.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } bp_update_t;

endpackage

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import frontend_pkg::*; (
    input  logic                         clk,
    input  logic                         prev_rst,
    input  logic                         flush,
    input  logic [31:0]                  redirect_pc,
    input  logic                         fifo_ready,
    input  inst_block_t                  wb_dat_i,
    input  logic                         wb_ack,
    input  logic                         redirect_en,
    input  logic [31:0]                  redirect_target,
    input  logic [IF_WIDTH-1:0]          slot_valid,
    input  lane_pred_t [IF_WIDTH-1:0]    lane_preds,
    output logic                         fifo_valid,
    output fetch_packet_t                fifo_packet,
    output logic [31:0]                  fetch_pc,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [31:0]                  wb_adr
);

    logic [31:0]   pc_q;                 // Fetch pc, offset bits kept.
    logic [31:0]   blk_pc;
    logic [31:0]   next_pc;
    logic [31:0]   adr_q;
    logic          busy;                 // Wishbone cycle open.
    logic          drop;                 // Flushed while busy.
    logic          launch;
    fetch_packet_t pkt_q;

    assign blk_pc = {pc_q[31:BLK_OFF_W], {BLK_OFF_W{1'b0}}};

    // Start a cycle when idle, or when the held packet leaves or is flushed.
    assign launch = ~busy & (~fifo_valid | fifo_ready | flush);

    always_comb begin
        if (flush) begin
            next_pc = redirect_pc;
        end else if (fifo_valid && redirect_en) begin
            next_pc = redirect_target;
        end else if (fifo_valid) begin
            next_pc = blk_pc + 32'(BLK_BYTES);
        end else begin
            next_pc = pc_q;                  // Idle, refetch the held pc.
        end
    end

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            pc_q       <= RESET_PC;
            busy       <= 1'b0;
            drop       <= 1'b0;
            fifo_valid <= 1'b0;
        end else if (launch) begin
            pc_q       <= next_pc;
            busy       <= 1'b1;
            fifo_valid <= 1'b0;
        end else if (busy && wb_ack) begin
            busy       <= 1'b0;
            drop       <= 1'b0;
            fifo_valid <= ~(drop | flush);   // Stale data is discarded.
            if (flush) begin
                pc_q <= redirect_pc;
            end
        end else if (busy && flush) begin
            drop <= 1'b1;
            pc_q <= redirect_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q <= {next_pc[31:BLK_OFF_W], {BLK_OFF_W{1'b0}}};
        end
        if (busy && wb_ack) begin
            pkt_q.pc    <= blk_pc;
            pkt_q.insts <= wb_dat_i;
            pkt_q.valid <= slot_valid;
            for (int i = 0; i < IF_WIDTH; i++) begin
                pkt_q.predict_taken[i]  <= lane_preds[i].taken;
                pkt_q.predict_target[i] <= lane_preds[i].target;
            end
        end
    end

    assign fifo_packet = pkt_q;
    assign fetch_pc    = pc_q;
    assign wb_cyc      = busy;
    assign wb_stb      = busy;
    assign wb_we       = 1'b0;               // Read only.
    assign wb_adr      = adr_q;

endmodule

/* rtl/bp_lane.sv */
`timescale 1ns/1ps

module bp_lane import frontend_pkg::*; #(
    parameter int SLOT = 0
) (
    input  logic        clk,
    input  logic        prev_rst,
    input  logic [31:0] fetch_pc,
    input  bp_update_t  update,
    output lane_pred_t  pred
);

    logic [1:0]           bht [BHT_ENTRIES];
    logic [BTB_ENTRIES-1:0] btb_valid;
    logic [BTB_TAG_W-1:0] btb_tag [BTB_ENTRIES];
    logic [31:0]          btb_target [BTB_ENTRIES];

    logic [BHT_IDX_W-1:0] f_bht_idx;
    logic [BTB_IDX_W-1:0] f_btb_idx;
    logic [BTB_TAG_W-1:0] f_tag;
    logic [BHT_IDX_W-1:0] u_bht_idx;
    logic [BTB_IDX_W-1:0] u_btb_idx;
    logic [BTB_TAG_W-1:0] u_tag;
    logic [1:0]           u_ctr;
    logic                 btb_hit;
    logic                 upd_en;

    assign f_bht_idx = fetch_pc[BLK_OFF_W +: BHT_IDX_W];
    assign f_btb_idx = fetch_pc[BLK_OFF_W +: BTB_IDX_W];
    assign f_tag     = fetch_pc[31 -: BTB_TAG_W];
    assign u_bht_idx = update.pc[BLK_OFF_W +: BHT_IDX_W];
    assign u_btb_idx = update.pc[BLK_OFF_W +: BTB_IDX_W];
    assign u_tag     = update.pc[31 -: BTB_TAG_W];
    assign u_ctr     = bht[u_bht_idx];

    // Only the lane owning the branch's slot learns from it.
    assign upd_en = update.valid && (update.pc[BLK_OFF_W-1:2] == IF_IDX_W'(SLOT));

    assign btb_hit = btb_valid[f_btb_idx] && (btb_tag[f_btb_idx] == f_tag);
    assign pred    = '{taken: bht[f_bht_idx][1] & btb_hit, target: btb_target[f_btb_idx]};

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;             // Weakly not taken.
            end
            btb_valid <= '0;
        end else if (upd_en) begin
            if (update.taken && u_ctr != 2'b11) begin
                bht[u_bht_idx] <= u_ctr + 2'd1;
            end else if (!update.taken && u_ctr != 2'b00) begin
                bht[u_bht_idx] <= u_ctr - 2'd1;
            end
            if (update.taken) begin
                btb_valid[u_btb_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en && update.taken) begin
            btb_tag[u_btb_idx]    <= u_tag;
            btb_target[u_btb_idx] <= update.target;
        end
    end

endmodule

/* rtl/taken_select.sv */
`timescale 1ns/1ps

module taken_select import frontend_pkg::*; (
    input  logic [31:0]               fetch_pc,
    input  lane_pred_t [IF_WIDTH-1:0] lane_preds,
    output logic                      redirect_en,
    output logic [31:0]               redirect_target,
    output logic [IF_WIDTH-1:0]       slot_valid
);

    logic [IF_IDX_W-1:0] offset;
    logic [IF_IDX_W-1:0] taken_idx;
    logic                found;

    assign offset = fetch_pc[BLK_OFF_W-1:2];     // Entry slot within the block.

    // Walk downwards so the lowest taken slot at or after the offset wins.
    always_comb begin
        found     = 1'b0;
        taken_idx = '0;
        for (int i = IF_WIDTH - 1; i >= 0; i--) begin
            if (IF_IDX_W'(i) >= offset && lane_preds[i].taken) begin
                found     = 1'b1;
                taken_idx = IF_IDX_W'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            slot_valid[i] = (IF_IDX_W'(i) >= offset) &&
                            (!found || IF_IDX_W'(i) <= taken_idx);
        end
    end

    assign redirect_en     = found;
    assign redirect_target = lane_preds[taken_idx].target;

endmodule

/* rtl/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; (
    input  logic          clk,
    input  logic          prev_rst,
    input  logic          flush,
    input  logic [31:0]   redirect_pc,
    output logic          fifo_valid,
    input  logic          fifo_ready,
    output fetch_packet_t fifo_packet,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic [31:0]   wb_adr,
    output logic          wb_we,
    input  inst_block_t   wb_dat_i,
    input  logic          wb_ack,
    input  bp_update_t    update
);

    logic [31:0]               fetch_pc;
    lane_pred_t [IF_WIDTH-1:0] lane_preds;
    logic                      redirect_en;
    logic [31:0]               redirect_target;
    logic [IF_WIDTH-1:0]       slot_valid;

    fetch_stage u_fetch (
        .clk             (clk),
        .prev_rst        (prev_rst),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .fifo_ready      (fifo_ready),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack),
        .redirect_en     (redirect_en),
        .redirect_target (redirect_target),
        .slot_valid      (slot_valid),
        .lane_preds      (lane_preds),
        .fifo_valid      (fifo_valid),
        .fifo_packet     (fifo_packet),
        .fetch_pc        (fetch_pc),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr)
    );

    // One predictor lane per instruction slot.
    for (genvar g = 0; g < IF_WIDTH; g++) begin : g_lane
        bp_lane #(
            .SLOT (g)
        ) u_lane (
            .clk      (clk),
            .prev_rst (prev_rst),
            .fetch_pc (fetch_pc),
            .update   (update),
            .pred     (lane_preds[g])
        );
    end

    taken_select u_select (
        .fetch_pc        (fetch_pc),
        .lane_preds      (lane_preds),
        .redirect_en     (redirect_en),
        .redirect_target (redirect_target),
        .slot_valid      (slot_valid)
    );

endmodule

/* tests/imem_model.sv */
`timescale 1ns/1ps

module imem_model import frontend_pkg::*; (
    input  logic        clk,
    input  logic        prev_rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    output inst_block_t wb_dat,
    output logic        wb_ack,
    input  logic [31:0] peek_adr,
    output inst_block_t peek_data
);

    integer      seed = 54;
    logic        ack_q = 1'b0;
    inst_block_t dat_q = '0;
    logic        active = 1'b0;          // Request seen and delay drawn.
    logic [1:0]  wait_cnt = 2'd0;

    function automatic logic [31:0] word_at(logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c96e1;
    endfunction

    function automatic inst_block_t block_at(logic [31:0] a);
        inst_block_t b;
        for (int i = 0; i < IF_WIDTH; i++) begin
            b[i] = word_at({a[31:BLK_OFF_W], {BLK_OFF_W{1'b0}}} + 32'(4 * i));
        end
        return b;
    endfunction

    assign peek_data = block_at(peek_adr);
    assign wb_ack    = ack_q;
    assign wb_dat    = dat_q;

    always @(posedge clk) begin
        if (prev_rst || ack_q) begin
            ack_q  <= 1'b0;
            active <= 1'b0;
        end else if (wb_cyc && wb_stb && !wb_we) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= 2'($unsigned($random(seed)) % 4);
            end else if (wait_cnt == 2'd0) begin
                ack_q <= 1'b1;
                dat_q <= block_at(wb_adr);  // Data comes with the ack.
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* tests/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb import frontend_pkg::*; ();

    logic                clk;
    logic                prev_rst;
    logic                flush;
    logic [31:0]         redirect_pc;
    logic                fifo_valid;
    logic                fifo_ready;
    fetch_packet_t       fifo_packet;
    logic                wb_cyc;
    logic                wb_stb;
    logic [31:0]         wb_adr;
    logic                wb_we;
    inst_block_t         wb_dat;
    logic                wb_ack;
    bp_update_t          update;
    inst_block_t         mem_block;      // Memory contents at the packet pc.

    logic                xfer;
    int                  cycle = 0;
    int                  xfer_count = 0;
    logic [31:0]         exp_pc;         // Block pc of the next packet to transfer.
    int                  exp_off;
    logic [IF_WIDTH-1:0] exp_mask;
    logic [IF_WIDTH-1:0] exp_taken;
    logic                trained;
    logic [31:0]         br_pc;
    logic [31:0]         br_target;
    logic                at_branch;
    logic                hit_branch;
    logic                drop_open;      // Flushed while a bus cycle is open.

    frontend_top uut (
        .clk         (clk),
        .prev_rst    (prev_rst),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fifo_valid  (fifo_valid),
        .fifo_ready  (fifo_ready),
        .fifo_packet (fifo_packet),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_we       (wb_we),
        .wb_dat_i    (wb_dat),
        .wb_ack      (wb_ack),
        .update      (update)
    );

    imem_model imem (
        .clk       (clk),
        .prev_rst  (prev_rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat),
        .wb_ack    (wb_ack),
        .peek_adr  (fifo_packet.pc),
        .peek_data (mem_block)
    );

    function automatic logic [31:0] block_pc(logic [31:0] a);
        return {a[31:BLK_OFF_W], {BLK_OFF_W{1'b0}}};
    endfunction

    function automatic logic [IF_WIDTH-1:0] slots_between(int first, int last);
        logic [IF_WIDTH-1:0] m;
        for (int i = 0; i < IF_WIDTH; i++) begin
            m[i] = (i >= first) && (i <= last);
        end
        return m;
    endfunction

    task automatic stop_failed();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic flag_mismatch(string msg);
        $display("ERROR %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic give_up_waiting(string what);
        $display("Timed out waiting for %s", what);
        stop_failed();
    endtask

    assign xfer = fifo_valid && fifo_ready;

    always_comb begin
        at_branch  = trained && exp_pc == block_pc(br_pc);
        hit_branch = at_branch && exp_off <= int'(br_pc[BLK_OFF_W-1:2]);
        exp_mask   = slots_between(exp_off,
                                   hit_branch ? int'(br_pc[BLK_OFF_W-1:2]) : IF_WIDTH - 1);
        exp_taken  = '0;
        if (at_branch) begin
            exp_taken[br_pc[BLK_OFF_W-1:2]] = 1'b1;
        end
    end

    // Reference of where the next transferred block must come from.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (prev_rst) begin
            exp_pc    <= RESET_PC;
            exp_off   <= 0;
            drop_open <= 1'b0;
        end else begin
            if (flush) begin
                exp_pc  <= block_pc(redirect_pc);
                exp_off <= int'(redirect_pc[BLK_OFF_W-1:2]);
            end else if (xfer) begin
                exp_pc  <= hit_branch ? block_pc(br_target) : exp_pc + 32'(BLK_BYTES);
                exp_off <= hit_branch ? int'(br_target[BLK_OFF_W-1:2]) : 0;
            end
            if (xfer) begin
                xfer_count <= xfer_count + 1;
            end
            drop_open <= wb_cyc && !wb_ack && (flush || drop_open);
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        prev_rst && cycle > 0 |-> !fifo_valid && !wb_cyc && !wb_stb)
        else flag_mismatch("fifo_valid, wb_cyc or wb_stb high during reset");
    a_first_fetch: assert property (@(posedge clk)
        $fell(prev_rst) |=> wb_cyc && wb_adr == RESET_PC)
        else flag_mismatch("no bus cycle to the reset vector after reset");
    a_packet_pc: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> fifo_packet.pc == exp_pc && fifo_packet.valid == exp_mask)
        else flag_mismatch("packet pc or valid mask differs from the expected block");
    a_pred_taken: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> fifo_packet.predict_taken == exp_taken)
        else flag_mismatch("predict_taken vector is wrong");
    a_pred_target: assert property (@(posedge clk) disable iff (prev_rst)
        xfer && at_branch |-> fifo_packet.predict_target[br_pc[BLK_OFF_W-1:2]] == br_target)
        else flag_mismatch("predicted target of the trained slot is wrong");
    a_insts: assert property (@(posedge clk) disable iff (prev_rst)
        fifo_valid |-> fifo_packet.insts == mem_block)
        else flag_mismatch("packet instructions differ from memory");
    a_hold: assert property (@(posedge clk) disable iff (prev_rst)
        fifo_valid && !fifo_ready && !flush |=> fifo_valid && $stable(fifo_packet) && !wb_stb)
        else flag_mismatch("packet changed or bus cycle started under back-pressure");
    a_wb_lines: assert property (@(posedge clk) disable iff (prev_rst)
        wb_cyc == wb_stb && !wb_we && (!wb_cyc || wb_adr[BLK_OFF_W-1:0] == '0))
        else flag_mismatch("cyc, stb, we or address alignment is wrong");
    a_wb_wait: assert property (@(posedge clk) disable iff (prev_rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else flag_mismatch("bus cycle dropped or address moved before ack");
    a_wb_end: assert property (@(posedge clk) disable iff (prev_rst)
        wb_cyc && wb_ack |=> !wb_cyc)
        else flag_mismatch("bus cycle still open after ack");
    a_fill: assert property (@(posedge clk) disable iff (prev_rst)
        wb_cyc && wb_ack && !flush && !drop_open |=> fifo_valid)
        else flag_mismatch("packet not valid in the cycle after ack");
    a_refetch: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |=> wb_cyc)
        else flag_mismatch("no new bus cycle after a transfer");

    task automatic wait_transfers(int n);
        int target;
        int t;
        target = xfer_count + n;
        t = 0;
        while (xfer_count < target) begin
            if (t == 20 * n) begin
                give_up_waiting("packet transfers");
            end else begin
                @(posedge clk);
                #1;
                t++;
            end
        end
    endtask

    task automatic wait_valid();
        int t;
        t = 0;
        while (!fifo_valid) begin
            if (t == 20) begin
                give_up_waiting("a valid packet");
            end else begin
                @(posedge clk);
                #1;
                t++;
            end
        end
    endtask

    task automatic wait_bus_open();
        int t;
        t = 0;
        while (!wb_cyc) begin
            if (t == 20) begin
                give_up_waiting("an open bus cycle");
            end else begin
                @(posedge clk);
                #1;
                t++;
            end
        end
    endtask

    task automatic flush_to(logic [31:0] addr);
        logic ready_was;
        ready_was   = fifo_ready;
        fifo_ready  = 1'b0;                  // Held packet is dropped, not sent.
        flush       = 1'b1;
        redirect_pc = addr;
        @(posedge clk);
        #1;
        flush      = 1'b0;
        fifo_ready = ready_was;
    endtask

    task automatic send_update(logic [31:0] pc, logic [31:0] target);
        update.valid  = 1'b1;
        update.pc     = pc;
        update.taken  = 1'b1;
        update.target = target;
        @(posedge clk);
        #1;
        update = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        prev_rst    = 1'b1;
        flush       = 1'b0;
        redirect_pc = '0;
        fifo_ready  = 1'b0;
        update      = '0;
        trained     = 1'b0;
        br_pc       = '0;
        br_target   = '0;
        repeat (16) @(posedge clk);
        #1;
        prev_rst   = 1'b0;
        fifo_ready = 1'b1;
        wait_transfers(6);                   // Reset vector, then sequential blocks.

        fifo_ready = 1'b0;
        wait_valid();
        repeat (5) @(posedge clk);
        #1;
        fifo_ready = 1'b1;
        wait_transfers(1);

        fifo_ready = 1'b0;
        wait_valid();
        flush_to(32'h0002_3468);             // Entry at slot 2.
        fifo_ready = 1'b1;
        wait_transfers(2);

        send_update(32'h0000_4a44, 32'h0000_7c24);
        send_update(32'h0000_4a44, 32'h0000_7c24);
        br_pc     = 32'h0000_4a44;
        br_target = 32'h0000_7c24;
        trained   = 1'b1;
        flush_to(32'h0000_4a40);
        wait_transfers(3);

        wait_bus_open();
        flush_to(32'h0001_0000);
        wait_transfers(2);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* build.f */
rtl/frontend_pkg.sv
rtl/fetch_stage.sv
rtl/bp_lane.sv
rtl/taken_select.sv
rtl/frontend_top.sv
tests/imem_model.sv
tests/frontend_tb.sv

/* run.sh */
#!/bin/sh
# Build the frontend testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module frontend_tb -f build.f \
    -Mdir obj_dir -o frontend_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit "$status"
fi

./obj_dir/frontend_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
